/* logic/sine_quarter_table.svh */
// quarter-wave sine magnitudes for the tone oscillator
// entry k = round(8191 * sin((k + 0.5) * pi / 128))

// half-step offset keeps the mirror symmetric, no entry sits on zero
localparam logic [12:0] SINE_QUARTER [64] = '{
  // k = 0 .. 7
  13'd101,  13'd301,  13'd502,  13'd703,
  13'd903,  13'd1102, 13'd1301, 13'd1499,
  // k = 8 .. 15
  13'd1696, 13'd1893, 13'd2088, 13'd2281,
  13'd2474, 13'd2665, 13'd2854, 13'd3041,
  // k = 16 .. 23
  13'd3227, 13'd3411, 13'd3593, 13'd3772,
  13'd3950, 13'd4124, 13'd4297, 13'd4467,
  // k = 24 .. 31
  13'd4634, 13'd4798, 13'd4960, 13'd5118,
  13'd5274, 13'd5426, 13'd5575, 13'd5720,
  // k = 32 .. 39
  13'd5863, 13'd6001, 13'd6136, 13'd6267,
  13'd6395, 13'd6519, 13'd6638, 13'd6754,
  // k = 40 .. 47
  13'd6866, 13'd6973, 13'd7077, 13'd7176,
  13'd7271, 13'd7361, 13'd7447, 13'd7528,
  // k = 48 .. 55
  13'd7605, 13'd7678, 13'd7745, 13'd7809,
  13'd7867, 13'd7921, 13'd7969, 13'd8013,
  // k = 56 .. 63, approaching full scale
  13'd8053, 13'd8087, 13'd8116, 13'd8141,
  13'd8161, 13'd8176, 13'd8185, 13'd8190
};

/* logic/wspr_pkg.sv */
// wspr beacon shared definitions
// band and tone types, register map, reset tone words, message symbols
`default_nettype none

package wspr_pkg;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  // bands in rotation order
  typedef enum logic [1:0] {
    band_40m = 2'd0,
    band_30m = 2'd1,
    band_20m = 2'd2
  } band_t;

  // nco phase increment, f = word / 2^32 * f_clk
  typedef logic [31:0] tone_word_t;

  // 4-fsk tone number
  typedef logic [1:0] symbol_t;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////

  localparam int NUM_BANDS         = 3;
  localparam int TONES_PER_BAND    = 4;
  localparam int NUM_TONE_WORDS    = NUM_BANDS * TONES_PER_BAND;
  localparam int SYMBOLS_PER_FRAME = 162;
  localparam int SYMBOL_INDEX_W    = 8;
  localparam int DAC_W             = 14;

  // apb map, tone word at band*16 + tone*4
  localparam logic [7:0] ADDR_TONE_BASE   = 8'h00;
  localparam logic [7:0] ADDR_BAND_ENABLE = 8'h40;

  // reference phase words, 1.4648 hz tone spacing at 122.88 mhz
  localparam tone_word_t RESET_TONE_WORDS [NUM_BANDS][TONES_PER_BAND] = '{
    '{32'd246069330, 32'd246069381, 32'd246069432, 32'd246069484},
    '{32'd354425679, 32'd354425730, 32'd354425781, 32'd354425832},
    '{32'd492729358, 32'd492729409, 32'd492729460, 32'd492729511}
  };

  // beacon message, one tone number per symbol
  localparam symbol_t MESSAGE_SYMBOLS [SYMBOLS_PER_FRAME] = '{
    2'd3, 2'd3, 2'd0, 2'd0, 2'd2, 2'd0, 2'd0, 2'd0, 2'd1, 2'd0, 2'd2, 2'd0, 2'd1, 2'd3, 2'd1, 2'd2,
    2'd2, 2'd2, 2'd1, 2'd0, 2'd3, 2'd1, 2'd0, 2'd3, 2'd3, 2'd1, 2'd3, 2'd0, 2'd0, 2'd2, 2'd0, 2'd2,
    2'd2, 2'd0, 2'd0, 2'd1, 2'd3, 2'd2, 2'd1, 2'd0, 2'd2, 2'd2, 2'd2, 2'd2, 2'd3, 2'd0, 2'd3, 2'd1,
    2'd0, 2'd0, 2'd3, 2'd0, 2'd2, 2'd3, 2'd0, 2'd1, 2'd3, 2'd0, 2'd2, 2'd1, 2'd0, 2'd2, 2'd2, 2'd1,
    2'd2, 2'd0, 2'd3, 2'd3, 2'd2, 2'd0, 2'd1, 2'd3, 2'd3, 2'd2, 2'd0, 2'd2, 2'd0, 2'd3, 2'd0, 2'd0,
    2'd1, 2'd0, 2'd2, 2'd1, 2'd3, 2'd2, 2'd2, 2'd1, 2'd1, 2'd0, 2'd0, 2'd3, 2'd2, 2'd3, 2'd0, 2'd2,
    2'd0, 2'd1, 2'd3, 2'd2, 2'd1, 2'd3, 2'd0, 2'd2, 2'd3, 2'd3, 2'd0, 2'd0, 2'd2, 2'd2, 2'd2, 2'd1,
    2'd3, 2'd1, 2'd2, 2'd0, 2'd0, 2'd1, 2'd0, 2'd2, 2'd3, 2'd2, 2'd1, 2'd3, 2'd0, 2'd0, 2'd3, 2'd2,
    2'd0, 2'd2, 2'd0, 2'd1, 2'd1, 2'd0, 2'd3, 2'd2, 2'd3, 2'd3, 2'd2, 2'd0, 2'd2, 2'd2, 2'd1, 2'd3,
    2'd2, 2'd1, 2'd2, 2'd0, 2'd3, 2'd0, 2'd0, 2'd1, 2'd2, 2'd2, 2'd1, 2'd3, 2'd3, 2'd2, 2'd3, 2'd0,
    2'd3, 2'd2
  };

endpackage

`default_nettype wire

/* logic/tone_word_regs.sv */
// apb tone register block
// twelve nco tone words and the band enable mask, zero wait states
`timescale 1ns/1ps
`default_nettype none

module tone_word_regs (
  input  wire logic                                          C122_clk,
  input  wire logic                                          reset,
  input  wire logic [7:0]                                    paddr,
  input  wire logic                                          psel,
  input  wire logic                                          penable,
  input  wire logic                                          pwrite,
  input  wire logic [31:0]                                   pwdata,
  output logic      [31:0]                                   prdata,
  output logic                                               pready,
  output logic                                               pslverr,
  output wspr_pkg::tone_word_t [wspr_pkg::NUM_TONE_WORDS-1:0] tone_words,
  output logic      [wspr_pkg::NUM_BANDS-1:0]                band_enable
);

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  logic       access;
  logic       aligned;
  logic       hit_tone;
  logic       hit_mask;
  logic       valid;
  logic [7:0] tone_offset;
  logic [3:0] tone_sel;

  // access phase of a transfer
  assign access = psel && penable;
  assign aligned = (paddr[1:0] == 2'b00);

  // tone words fill 0x00..0x2f, band in [5:4], tone in [3:2]
  assign tone_offset = paddr - wspr_pkg::ADDR_TONE_BASE;
  assign tone_sel = tone_offset[5:2];
  assign hit_tone = aligned && (paddr >= wspr_pkg::ADDR_TONE_BASE) &&
                    (tone_offset < 8'(wspr_pkg::NUM_TONE_WORDS * 4));
  assign hit_mask = (paddr == wspr_pkg::ADDR_BAND_ENABLE);
  assign valid = hit_tone || hit_mask;

  // never stalls
  assign pready = 1'b1;
  assign pslverr = access && !valid;

  // read mux, zero outside the map
  always_comb begin
    prdata = '0;
    if (hit_tone) begin
      prdata = tone_words[tone_sel];
    end else if (hit_mask) begin
      prdata = 32'(band_enable);
    end
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge C122_clk) begin
    if (reset) begin
      // reference phase words, all bands on
      for (int b = 0; b < wspr_pkg::NUM_BANDS; b++) begin
        for (int t = 0; t < wspr_pkg::TONES_PER_BAND; t++) begin
          tone_words[b * wspr_pkg::TONES_PER_BAND + t] <= wspr_pkg::RESET_TONE_WORDS[b][t];
        end
      end
      band_enable <= '1;
    end else if (access && pwrite && valid) begin
      if (hit_tone) begin
        tone_words[tone_sel] <= pwdata;
      end else begin
        // upper mask bits are ignored
        band_enable <= pwdata[wspr_pkg::NUM_BANDS-1:0];
      end
    end
  end

  // access phase only follows a setup phase
  a_penable_needs_psel: assert property (
    @(posedge C122_clk) disable iff (reset) penable |-> psel
  );

endmodule

`default_nettype wire

/* logic/wspr_frame_timer.sv */
// wspr frame timer
// frame and symbol counters, band rotation and the transmit window
`timescale 1ns/1ps
`default_nettype none

module wspr_frame_timer #(
  parameter longint unsigned CYCLES_PER_SYMBOL = 64'd83886080,
  parameter longint unsigned CYCLES_PER_FRAME  = 64'd14745600000
) (
  input  wire logic                                     C122_clk,
  input  wire logic                                     reset,
  input  wire logic [wspr_pkg::NUM_BANDS-1:0]           band_enable,
  output logic                                          frame_start,
  output logic                                          symbol_tick,
  output wspr_pkg::band_t                               band,
  output logic      [wspr_pkg::SYMBOL_INDEX_W-1:0]      symbol_index,
  output logic                                          tx_window
);

  localparam int SYM_W   = $clog2(CYCLES_PER_SYMBOL);
  localparam int FRAME_W = $clog2(CYCLES_PER_FRAME);
  localparam logic [wspr_pkg::SYMBOL_INDEX_W-1:0] LAST_INDEX =
    wspr_pkg::SYMBOL_INDEX_W'(wspr_pkg::SYMBOLS_PER_FRAME);

  logic [FRAME_W-1:0] frame_cnt;
  logic [SYM_W-1:0]   sym_cnt;
  logic               frame_last;
  logic               sym_last;
  logic               sym_pre_last;
  logic               sending;
  logic               started;
  logic               band_on;
  wspr_pkg::band_t    band_next;

  // rotation 40 -> 30 -> 20 -> 40
  function automatic wspr_pkg::band_t next_band(input wspr_pkg::band_t cur);
    case (cur)
      wspr_pkg::band_40m: next_band = wspr_pkg::band_30m;
      wspr_pkg::band_30m: next_band = wspr_pkg::band_20m;
      default:            next_band = wspr_pkg::band_40m;
    endcase
  endfunction

  assign frame_last   = (frame_cnt == FRAME_W'(CYCLES_PER_FRAME - 1));
  assign sym_last     = (sym_cnt == SYM_W'(CYCLES_PER_SYMBOL - 1));
  assign sym_pre_last = (sym_cnt == SYM_W'(CYCLES_PER_SYMBOL - 2));
  assign sending      = (symbol_index < LAST_INDEX);

  // first frame stays on 40 m
  assign band_next = started ? next_band(band) : band;

  ////////////////////////////////////////
  // frame and symbol counters
  ////////////////////////////////////////

  always_ff @(posedge C122_clk) begin
    if (reset) begin
      // preload so the first frame starts right after reset
      frame_cnt    <= FRAME_W'(CYCLES_PER_FRAME - 1);
      sym_cnt      <= '0;
      symbol_index <= LAST_INDEX;
      band         <= wspr_pkg::band_40m;
      started      <= 1'b0;
      band_on      <= 1'b0;
      frame_start  <= 1'b0;
      symbol_tick  <= 1'b0;
      tx_window    <= 1'b0;
    end else begin
      frame_start <= frame_last;
      // window lines up with the oscillator amplitude register
      tx_window   <= band_on && sending;
      if (frame_last) begin
        frame_cnt    <= '0;
        sym_cnt      <= '0;
        symbol_index <= '0;
        symbol_tick  <= 1'b0;
        started      <= 1'b1;
        band         <= band_next;
        // mask sampled once per frame
        band_on      <= band_enable[band_next];
      end else begin
        frame_cnt   <= frame_cnt + 1'b1;
        // tick in the last cycle of each symbol
        symbol_tick <= sym_pre_last && sending;
        if (sym_last) begin
          sym_cnt <= '0;
          if (sending) begin
            symbol_index <= symbol_index + 1'b1;
          end
        end else begin
          sym_cnt <= sym_cnt + 1'b1;
        end
      end
    end
  end

  a_index_in_range: assert property (
    @(posedge C122_clk) disable iff (reset) symbol_index <= LAST_INDEX
  );

  // message done, the window closes on the next cycle
  a_window_closes: assert property (
    @(posedge C122_clk) disable iff (reset) (symbol_index == LAST_INDEX) |=> !tx_window
  );

endmodule

`default_nettype wire

/* logic/fsk_tone_nco.sv */
// 4-fsk tone oscillator
// message symbol lookup, tone word select, phase accumulator and sine output
`timescale 1ns/1ps
`default_nettype none

module fsk_tone_nco (
  input  wire logic                                           C122_clk,
  input  wire logic                                           reset,
  input  wire logic                                           frame_start,
  input  wire wspr_pkg::band_t                                band,
  input  wire logic [wspr_pkg::SYMBOL_INDEX_W-1:0]            symbol_index,
  input  wire wspr_pkg::tone_word_t [wspr_pkg::NUM_TONE_WORDS-1:0] tone_words,
  output logic signed [wspr_pkg::DAC_W-1:0]                   amplitude
);

  `include "sine_quarter_table.svh"

  localparam logic [wspr_pkg::SYMBOL_INDEX_W-1:0] LAST_INDEX =
    wspr_pkg::SYMBOL_INDEX_W'(wspr_pkg::SYMBOLS_PER_FRAME);

  ////////////////////////////////////////
  // tone selection
  ////////////////////////////////////////

  logic                 in_message;
  wspr_pkg::symbol_t    symbol;
  wspr_pkg::tone_word_t step;

  assign in_message = (symbol_index < LAST_INDEX);

  // past the last symbol the tone no longer matters
  assign symbol = in_message ? wspr_pkg::MESSAGE_SYMBOLS[symbol_index] : '0;

  // word index = band * 4 + tone
  assign step = tone_words[{band, symbol}];

  ////////////////////////////////////////
  // phase accumulator
  ////////////////////////////////////////

  logic [31:0] acc;
  logic [31:0] phase;

  // frame_start forces phase zero in the same cycle
  assign phase = frame_start ? '0 : acc;

  always_ff @(posedge C122_clk) begin
    if (reset) begin
      acc <= '0;
    end else if (frame_start || in_message) begin
      acc <= phase + step;
    end
  end

  ////////////////////////////////////////
  // sine lookup
  ////////////////////////////////////////

  logic [7:0]                      phase_index;
  logic [5:0]                      table_index;
  logic [12:0]                     magnitude;
  logic signed [wspr_pkg::DAC_W-1:0] sample;

  assign phase_index = phase[31:24];

  // second and fourth quadrant read the table backwards
  assign table_index = phase_index[6] ? ~phase_index[5:0] : phase_index[5:0];
  assign magnitude = SINE_QUARTER[table_index];

  // lower half cycle is negative
  always_comb begin
    sample = signed'({1'b0, magnitude});
    if (phase_index[7]) begin
      sample = -signed'({1'b0, magnitude});
    end
  end

  always_ff @(posedge C122_clk) begin
    amplitude <= sample;
  end

  // accumulator only moves while a message symbol is in force
  a_advance_in_message: assert property (
    @(posedge C122_clk) disable iff (reset)
    $changed(acc) |-> ($past(symbol_index) < LAST_INDEX)
  );

endmodule

`default_nettype wire

/* logic/beacon_output.sv */
// beacon output stage
// gated dac sample, transmit key and the one-second square wave
`timescale 1ns/1ps
`default_nettype none

module beacon_output #(
  parameter longint unsigned PPS_HALF_PERIOD = 64'd61440000
) (
  input  wire logic                                C122_clk,
  input  wire logic                                reset,
  input  wire logic signed [wspr_pkg::DAC_W-1:0]   amplitude,
  input  wire logic                                tx_window,
  output logic signed      [wspr_pkg::DAC_W-1:0]   dac,
  output logic                                     tx_key,
  output logic                                     pps
);

  localparam int PPS_W = $clog2(PPS_HALF_PERIOD);

  logic [PPS_W-1:0] pps_cnt;

  ////////////////////////////////////////
  // dac and key
  ////////////////////////////////////////

  always_ff @(posedge C122_clk) begin
    if (reset) begin
      dac    <= '0;
      tx_key <= 1'b0;
    end else begin
      // silent between transmissions
      dac    <= tx_window ? amplitude : '0;
      tx_key <= tx_window;
    end
  end

  ////////////////////////////////////////
  // pps
  ////////////////////////////////////////

  always_ff @(posedge C122_clk) begin
    if (reset) begin
      pps_cnt <= '0;
      pps     <= 1'b0;
    end else if (pps_cnt == PPS_W'(PPS_HALF_PERIOD - 1)) begin
      pps_cnt <= '0;
      pps     <= ~pps;
    end else begin
      pps_cnt <= pps_cnt + 1'b1;
    end
  end

  a_dac_quiet_unkeyed: assert property (
    @(posedge C122_clk) disable iff (reset) !tx_key |-> (dac == '0)
  );

endmodule

`default_nettype wire

/* logic/pennywspr_beacon.sv */
// wspr beacon core top
// apb tone registers, frame timer, tone oscillator and output stage
`timescale 1ns/1ps
`default_nettype none

module pennywspr_beacon #(
  parameter longint unsigned CYCLES_PER_SYMBOL = 64'd83886080,
  parameter longint unsigned CYCLES_PER_FRAME  = 64'd14745600000,
  parameter longint unsigned PPS_HALF_PERIOD   = 64'd61440000
) (
  input  wire logic                              C122_clk,
  input  wire logic                              reset,
  input  wire logic [7:0]                        paddr,
  input  wire logic                              psel,
  input  wire logic                              penable,
  input  wire logic                              pwrite,
  input  wire logic [31:0]                       pwdata,
  output logic      [31:0]                       prdata,
  output logic                                   pready,
  output logic                                   pslverr,
  output logic signed [wspr_pkg::DAC_W-1:0]      dac,
  output logic                                   tx_key,
  output wspr_pkg::band_t                        band,
  output logic                                   pps
);

  wspr_pkg::tone_word_t [wspr_pkg::NUM_TONE_WORDS-1:0] tone_words;
  logic [wspr_pkg::NUM_BANDS-1:0]                      band_enable;
  logic                                                frame_start;
  logic                                                symbol_tick;
  logic [wspr_pkg::SYMBOL_INDEX_W-1:0]                 symbol_index;
  logic                                                tx_window;
  logic signed [wspr_pkg::DAC_W-1:0]                   amplitude;

  ////////////////////////////////////////
  // input side
  ////////////////////////////////////////

  tone_word_regs tone_word_regs_i (
    .C122_clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr, .tone_words, .band_enable
  );

  ////////////////////////////////////////
  // processing
  ////////////////////////////////////////

  wspr_frame_timer #(
    .CYCLES_PER_SYMBOL (CYCLES_PER_SYMBOL),
    .CYCLES_PER_FRAME  (CYCLES_PER_FRAME)
  ) wspr_frame_timer_i (
    .C122_clk, .reset, .band_enable, .frame_start, .symbol_tick,
    .band, .symbol_index, .tx_window
  );

  fsk_tone_nco fsk_tone_nco_i (
    .C122_clk, .reset, .frame_start, .band, .symbol_index, .tone_words, .amplitude
  );

  ////////////////////////////////////////
  // output side
  ////////////////////////////////////////

  beacon_output #(
    .PPS_HALF_PERIOD (PPS_HALF_PERIOD)
  ) beacon_output_i (
    .C122_clk, .reset, .amplitude, .tx_window, .dac, .tx_key, .pps
  );

  // oscillator sees the next symbol right after each tick
  a_tick_steps_symbol: assert property (
    @(posedge C122_clk) disable iff (reset)
    symbol_tick |=> (symbol_index == $past(symbol_index) + 1'b1)
  );

endmodule

`default_nettype wire

/* verification/beacon_tb.sv */
// wspr beacon testbench
// apb configuration, cycle reference model and checking assertions on short frames
`timescale 1ns/1ps
`default_nettype none

module beacon_tb;

  `include "sine_quarter_table.svh"

  // short frames for simulation
  localparam int SYMBOL_CYCLES = 16;
  localparam int FRAME_CYCLES = 3000;
  localparam int PPS_CYCLES = 50;
  localparam int TX_CYCLES = wspr_pkg::SYMBOLS_PER_FRAME * SYMBOL_CYCLES;
  // four frames, configuration fits in the gaps
  localparam int WATCHDOG_CYCLES = 4 * FRAME_CYCLES;

  logic                              C122_clk;
  logic                              reset;
  logic [7:0]                        paddr;
  logic                              psel;
  logic                              penable;
  logic                              pwrite;
  logic [31:0]                       pwdata;
  logic [31:0]                       prdata;
  logic                              pready;
  logic                              pslverr;
  logic signed [wspr_pkg::DAC_W-1:0] dac;
  logic                              tx_key;
  wspr_pkg::band_t                   band;
  logic                              pps;

  pennywspr_beacon #(
    .CYCLES_PER_SYMBOL (SYMBOL_CYCLES),
    .CYCLES_PER_FRAME  (FRAME_CYCLES),
    .PPS_HALF_PERIOD   (PPS_CYCLES)
  ) pennywspr_beacon_i (
    .C122_clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr, .dac, .tx_key, .band, .pps
  );

  always #4 C122_clk = ~C122_clk;

  ////////////////////////////////////////
  // reference model state
  ////////////////////////////////////////

  wspr_pkg::tone_word_t              model_words [wspr_pkg::NUM_TONE_WORDS];
  logic [wspr_pkg::NUM_BANDS-1:0]    model_mask;
  int                                cyc;
  logic                              frame_on;
  logic [31:0]                       model_acc;
  wspr_pkg::band_t                   exp_band;
  logic                              exp_key;
  logic signed [wspr_pkg::DAC_W-1:0] exp_dac;
  logic                              exp_pps;
  logic [31:0]                       exp_rdata;
  logic                              exp_err;
  logic [31:0]                       rng_state;

  int err_apb;
  int err_key;
  int err_band;
  int err_dac;
  int err_pps;
  int err_wait;
  int err_mark;
  int tests_run;
  int tests_failed;

  // lcg, numerical recipes constants
  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // full sine wave from the quarter table, 256 phase steps
  function automatic logic signed [wspr_pkg::DAC_W-1:0] sine_at(input logic [7:0] idx);
    int quadrant;
    int k;
    int mag;
    quadrant = idx / 64;
    k = idx % 64;
    // falling quarters run the table backwards
    if (quadrant == 1 || quadrant == 3) begin
      k = 63 - k;
    end
    mag = SINE_QUARTER[k];
    if (quadrant >= 2) begin
      mag = -mag;
    end
    return wspr_pkg::DAC_W'(mag);
  endfunction

  function automatic int total_errors();
    return err_apb + err_key + err_band + err_dac + err_pps + err_wait;
  endfunction

  // cycle model, c counts rising edges since reset release
  always @(posedge C122_clk) begin : ref_model
    int c;
    int pos;
    int bnum;
    logic on;
    logic key;
    logic [31:0] acc;
    if (reset) begin
      cyc       <= 0;
      frame_on  <= 1'b0;
      model_acc <= '0;
      exp_band  <= wspr_pkg::band_40m;
      exp_key   <= 1'b0;
      exp_dac   <= '0;
      exp_pps   <= 1'b0;
    end else begin
      c = cyc + 1;
      pos = (c - 1) % FRAME_CYCLES;
      bnum = ((c - 1) / FRAME_CYCLES) % wspr_pkg::NUM_BANDS;
      // mask taken once, at the frame start edge
      on = frame_on;
      if (pos == 0) begin
        on = model_mask[bnum];
      end
      // key two cycles after frame start, one symbol run long
      key = on && (pos >= 2) && (pos < 2 + TX_CYCLES);
      acc = model_acc;
      if (key) begin
        if (pos == 2) begin
          acc = '0;
        end else begin
          acc = model_acc +
                model_words[bnum * 4 + wspr_pkg::MESSAGE_SYMBOLS[(pos - 3) / SYMBOL_CYCLES]];
        end
      end
      cyc       <= c;
      frame_on  <= on;
      model_acc <= acc;
      exp_band  <= wspr_pkg::band_t'(bnum);
      exp_key   <= key;
      exp_dac   <= key ? sine_at(acc[31:24]) : '0;
      exp_pps   <= ((c / PPS_CYCLES) % 2) == 1;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  a_band: assert property (@(posedge C122_clk) disable iff (reset) band == exp_band)
    else begin
      err_band++;
      $display("Mismatch at %0t: band expected %0d actual %0d",
               $time, $sampled(exp_band), $sampled(band));
    end

  a_key: assert property (@(posedge C122_clk) disable iff (reset) tx_key == exp_key)
    else begin
      err_key++;
      $display("Mismatch at %0t: tx_key expected %0b actual %0b",
               $time, $sampled(exp_key), $sampled(tx_key));
    end

  // also covers dac silent while unkeyed
  a_dac: assert property (@(posedge C122_clk) disable iff (reset) dac == exp_dac)
    else begin
      err_dac++;
      $display("Mismatch at %0t: dac expected %0d actual %0d",
               $time, $sampled(exp_dac), $sampled(dac));
    end

  a_pps: assert property (@(posedge C122_clk) disable iff (reset) pps == exp_pps)
    else begin
      err_pps++;
      $display("Mismatch at %0t: pps expected %0b actual %0b",
               $time, $sampled(exp_pps), $sampled(pps));
    end

  a_prdata: assert property (@(posedge C122_clk) disable iff (reset)
    (psel && penable && !pwrite) |-> (prdata == exp_rdata))
    else begin
      err_apb++;
      $display("Mismatch at %0t: prdata expected %08h actual %08h",
               $time, $sampled(exp_rdata), $sampled(prdata));
    end

  a_pslverr: assert property (@(posedge C122_clk) disable iff (reset)
    (psel && penable) |-> (pslverr == exp_err))
    else begin
      err_apb++;
      $display("Mismatch at %0t: pslverr expected %0b actual %0b",
               $time, $sampled(exp_err), $sampled(pslverr));
    end

  a_pready: assert property (@(posedge C122_clk) disable iff (reset) pready)
    else begin
      err_apb++;
      $display("Mismatch at %0t: pready expected 1 actual %0b", $time, $sampled(pready));
    end

  ////////////////////////////////////////
  // bus and wait tasks
  ////////////////////////////////////////

  // setup cycle, access cycle, then idle
  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data, input logic err);
    @(posedge C122_clk);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    exp_err = err;
    @(posedge C122_clk);
    #1;
    penable = 1'b1;
    @(posedge C122_clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
    if (!err) begin
      if (addr == wspr_pkg::ADDR_BAND_ENABLE) begin
        model_mask = data[wspr_pkg::NUM_BANDS-1:0];
      end else begin
        model_words[addr[5:2]] = data;
      end
    end
  endtask

  task automatic bus_read(input logic [7:0] addr, input logic [31:0] expected, input logic err);
    @(posedge C122_clk);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    exp_rdata = expected;
    exp_err = err;
    @(posedge C122_clk);
    #1;
    penable = 1'b1;
    @(posedge C122_clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_for_key(input logic level, input int limit);
    int n;
    n = 0;
    while (tx_key !== level && n < limit) begin
      @(posedge C122_clk);
      #1;
      n++;
    end
    if (tx_key !== level) begin
      err_wait++;
      $display("tx_key did not become %0b within %0d cycles", level, limit);
    end
  endtask

  task automatic wait_for_band(input wspr_pkg::band_t want, input int limit);
    int n;
    n = 0;
    while (band !== want && n < limit) begin
      @(posedge C122_clk);
      #1;
      n++;
    end
    if (band !== want) begin
      err_wait++;
      $display("band did not reach %s within %0d cycles", want.name(), limit);
    end
  endtask

  task automatic report_test(input string name);
    int n;
    n = total_errors() - err_mark;
    err_mark = total_errors();
    tests_run++;
    if (n == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, n);
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin : main
    logic [31:0] word;
    logic level;
    int n;
    C122_clk = 1'b0;
    reset = 1'b1;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    exp_rdata = '0;
    exp_err = 1'b0;
    rng_state = 32'h28f0;
    err_apb = 0;
    err_key = 0;
    err_band = 0;
    err_dac = 0;
    err_pps = 0;
    err_wait = 0;
    err_mark = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int i = 0; i < wspr_pkg::NUM_TONE_WORDS; i++) begin
      model_words[i] = wspr_pkg::RESET_TONE_WORDS[i / 4][i % 4];
    end
    model_mask = '1;
    repeat (4) @(posedge C122_clk);
    #1;
    reset = 1'b0;

    // reset values, then 20 m words while 40 m transmits
    for (int i = 0; i < wspr_pkg::NUM_TONE_WORDS; i++) begin
      bus_read(8'(i * 4), wspr_pkg::RESET_TONE_WORDS[i / 4][i % 4], 1'b0);
    end
    bus_read(wspr_pkg::ADDR_BAND_ENABLE, 32'h7, 1'b0);
    for (int i = 8; i < wspr_pkg::NUM_TONE_WORDS; i++) begin
      word = next_random();
      bus_write(8'(i * 4), word, 1'b0);
      bus_read(8'(i * 4), word, 1'b0);
    end
    bus_read(8'h80, 32'h0, 1'b1);
    bus_read(8'h06, 32'h0, 1'b1);
    bus_write(8'h44, 32'hffff_ffff, 1'b1);
    bus_read(wspr_pkg::ADDR_BAND_ENABLE, 32'h7, 1'b0);
    report_test("apb readback");

    // first frame keyed on 40 m
    wait_for_key(1'b1, FRAME_CYCLES);
    wait_for_key(1'b0, TX_CYCLES + 2);
    report_test("frame keying");

    // in the idle gap: top byte steps and 30 m masked off
    for (int i = 0; i < wspr_pkg::NUM_TONE_WORDS; i++) begin
      word = next_random();
      bus_write(8'(i * 4), {word[31:24], 24'h0}, 1'b0);
    end
    bus_write(wspr_pkg::ADDR_BAND_ENABLE, 32'h5, 1'b0);
    bus_read(wspr_pkg::ADDR_BAND_ENABLE, 32'h5, 1'b0);
    wait_for_band(wspr_pkg::band_30m, FRAME_CYCLES);
    wait_for_band(wspr_pkg::band_20m, FRAME_CYCLES + 1);
    report_test("band masking");

    wait_for_key(1'b1, 4);
    wait_for_key(1'b0, TX_CYCLES + 2);
    report_test("tone synthesis");

    // rotation wraps back to 40 m
    wait_for_band(wspr_pkg::band_40m, FRAME_CYCLES);
    wait_for_key(1'b1, 4);
    wait_for_key(1'b0, TX_CYCLES + 2);
    report_test("band wrap");

    // two more half periods
    for (int t = 0; t < 2; t++) begin
      level = pps;
      n = 0;
      while (pps === level && n <= PPS_CYCLES) begin
        @(posedge C122_clk);
        #1;
        n++;
      end
      if (pps === level) begin
        err_wait++;
        $display("pps did not toggle within %0d cycles", PPS_CYCLES + 1);
      end
    end
    report_test("pps");

    $display("%0d tests, %0d failed, errors apb %0d key %0d band %0d dac %0d pps %0d wait %0d",
             tests_run, tests_failed, err_apb, err_key, err_band, err_dac, err_pps, err_wait);
    if (total_errors() == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge C122_clk);
    $display("watchdog expired after %0d cycles before the tests completed", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* pennywspr_beacon.f */
+incdir+logic
logic/wspr_pkg.sv
logic/tone_word_regs.sv
logic/wspr_frame_timer.sv
logic/fsk_tone_nco.sv
logic/beacon_output.sv
logic/pennywspr_beacon.sv
verification/beacon_tb.sv
